//--- list.f
src/scope_pkg.sv
src/scope_cfg_if.sv
src/scope_regs.sv
src/sample_timebase.sv
src/channel_extractor.sv
src/capture_buffer.sv
src/stream_scope.sv
sim/scope_checker.sv
sim/tb_stream_scope.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_stream_scope -f list.f -o tb_stream_scope \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_stream_scope +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -q "sim failed" sim.log && exit 1 || grep -q "sim passed" sim.log

//--- sim/scope_checker.sv
`timescale 1ns/1ps

module scope_checker (
    input logic clock,
    input logic rst_n,
    input logic dma_done,
    input logic busy,
    input logic arm
);

    // Failure counts, read by the testbench at the end of the run
    int done_repeat_fails = 0;
    int done_idle_fails   = 0;
    int reset_fails       = 0;

    // The completion strobe is a single-cycle pulse
    done_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        dma_done |=> !dma_done)
        else begin
            $error("dma_done stayed high for two cycles in a row");
            done_repeat_fails++;
        end

    // Done can only end a capture that was running
    done_after_busy: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(dma_done) |-> $past(busy))
        else begin
            $error("dma_done rose although busy was low the cycle before");
            done_idle_fails++;
        end

    // Nothing starts or completes while reset is held
    quiet_in_reset: assert property (@(posedge clock) !rst_n |-> (!arm && !dma_done))
        else begin
            $error("arm or dma_done high during reset");
            reset_fails++;
        end

endmodule

bind stream_scope scope_checker u_checker (
    .clock    (clock),
    .rst_n    (rst_n),
    .dma_done (dma_done),
    .busy     (cfg_if.busy),
    .arm      (cfg_if.arm)
);

//--- sim/stream_scope_golden.txt
# W addr data | S tag data | R addr expected | D cycles | E external tick | P max cycles
# F frame word0 word1 word2 word3 | addr, tag and data in hex, cycles and frame in decimal
W 1 5a000011
W 2 5a000022
W 3 5a000033
W 4 5a000044
W 5 0000abcd
R 1 5a000011
R 2 5a000022
R 3 5a000033
R 4 5a000044
R 5 0000abcd
W 0 01000001
R 0 01000000
R 6 00000001
S 11 00001111
S 22 00002222
S 11 00001112
S 33 00003333
E
S 44 00004441
E
S 11 00001113
E
S 22 00002223
E
S 33 00003334
E
S 44 00004445
E
S 11 00001116
E
S 22 00002227
E
P 20
R 6 00000000
F 0 00001112 00002222 00003333 00000000
F 1 00001112 00002222 00003333 00004441
F 2 00001113 00002222 00003333 00004441
F 3 00001113 00002223 00003333 00004441
F 4 00001113 00002223 00003334 00004441
F 5 00001113 00002223 00003334 00004445
F 6 00001116 00002223 00003334 00004445
F 7 00001116 00002227 00003334 00004445
S 33 00009999
E
F 7 00001116 00002227 00003334 00004445
W 5 00000009
S 11 aaaa0001
S 22 aaaa0002
S 44 aaaa0004
W 0 00000001
R 0 00000000
R 6 00000001
P 100
R 6 00000000
F 0 aaaa0001 aaaa0002 00009999 aaaa0004
F 1 aaaa0001 aaaa0002 00009999 aaaa0004
F 2 aaaa0001 aaaa0002 00009999 aaaa0004
F 3 aaaa0001 aaaa0002 00009999 aaaa0004
F 4 aaaa0001 aaaa0002 00009999 aaaa0004
F 5 aaaa0001 aaaa0002 00009999 aaaa0004
F 6 aaaa0001 aaaa0002 00009999 aaaa0004
F 7 aaaa0001 aaaa0002 00009999 aaaa0004

//--- sim/tb_stream_scope.sv
`timescale 1ns/1ps

module tb_stream_scope;
    import scope_pkg::*;

    localparam int N_CHANNELS      = 4;
    localparam int CHANNEL_SAMPLES = 8;
    localparam int ADDR_W          = $clog2(N_CHANNELS * CHANNEL_SAMPLES);
    // The golden sequence runs one external and one internal capture
    localparam int N_CAPTURES      = 2;
    localparam int CYCLE_LIMIT     = CHANNEL_SAMPLES * 40 * N_CAPTURES + 2000;

    logic              clock;
    logic              rst_n;
    logic              reg_wr;
    logic              reg_rd;
    reg_addr_t         reg_addr;
    sample_t           reg_wdata;
    sample_t           reg_rdata;
    logic              in_valid;
    sample_t           in_data;
    dest_t             in_dest;
    logic              sampling_clock;
    logic [ADDR_W-1:0] buf_addr;
    sample_t           buf_rdata;
    logic              dma_done;

    // Tags currently programmed, so filler words never hit a channel
    dest_t sel_model [N_CHANNELS];
    int    value_errors  = 0;
    int    other_errors  = 0;
    int    done_count    = 0;
    int    done_expected = 0;
    int    cycle_count   = 0;

    // Frames already confirmed against the golden file
    sample_t frame_model [CHANNEL_SAMPLES][N_CHANNELS];
    logic    frame_known [CHANNEL_SAMPLES];
    // Set by an arm write and cleared once its done pulse has been awaited
    logic    capture_armed;

    stream_scope u_dut (
        .clock          (clock),
        .rst_n          (rst_n),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_dest        (in_dest),
        .sampling_clock (sampling_clock),
        .buf_addr       (buf_addr),
        .buf_rdata      (buf_rdata),
        .dma_done       (dma_done)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Cycle count for the timeout and a tally of every done pulse
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (dma_done) begin
            done_count <= done_count + 1;
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) @(posedge clock);
        $display("timeout after %0d cycles, the golden sequence did not finish", cycle_count);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        $display("sim failed");
        $finish;
    end

    task automatic compare_sample(input string name, input sample_t expected,
                                  input sample_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("error %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic compare_reg(input reg_addr_t addr, input sample_t expected,
                               input sample_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("error reg_rdata at %h: expected %h, got %h", addr, expected, actual);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input sample_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clock);
        reg_wr = 1'b0;
        for (int c = 0; c < N_CHANNELS; c++) begin
            if (int'(addr) == REG_SEL_BASE + c) begin
                sel_model[c] = data[DEST_WIDTH-1:0];
            end
        end
        if (int'(addr) == REG_CTRL && data[CTRL_ARM_BIT]) begin
            capture_armed = 1'b1;
        end
    endtask

    // The read data is registered on the strobe edge and checked one half cycle later
    task automatic read_reg(input reg_addr_t addr, input sample_t expected);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clock);
        reg_rd = 1'b0;
        compare_reg(addr, expected, reg_rdata);
    endtask

    function automatic dest_t filler_tag();
        dest_t tag;
        logic  hit;
        do begin
            tag = dest_t'($urandom);
            hit = 1'b0;
            for (int c = 0; c < N_CHANNELS; c++) begin
                if (tag == sel_model[c]) begin
                    hit = 1'b1;
                end
            end
        end while (hit);
        return tag;
    endfunction

    // Every golden word is preceded by a random word that no channel takes
    task automatic send_word(input dest_t tag, input sample_t data);
        in_valid = 1'b1;
        in_dest  = filler_tag();
        in_data  = $urandom;
        @(negedge clock);
        in_dest = tag;
        in_data = data;
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    // High long enough for the synchronizer, then low so the next edge is seen
    task automatic ext_tick();
        sampling_clock = 1'b1;
        repeat (5) @(negedge clock);
        sampling_clock = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    task automatic wait_done(input int max_cycles);
        int waited;
        waited = 0;
        done_expected++;
        while (done_count < done_expected && waited < max_cycles) begin
            @(negedge clock);
            waited++;
        end
        if (done_count < done_expected) begin
            other_errors++;
            $display("dma_done did not pulse within %0d cycles", max_cycles);
        end else if (done_count > done_expected) begin
            other_errors++;
            $display("dma_done pulsed more than once for one capture");
        end
        done_expected = done_count;
        capture_armed = 1'b0;
    endtask

    // Word c of frame f sits at address f * N_CHANNELS + c
    task automatic check_frame(input int frame, input sample_t expected [N_CHANNELS]);
        for (int c = 0; c < N_CHANNELS; c++) begin
            buf_addr = ADDR_W'(frame * N_CHANNELS + c);
            @(negedge clock);
            compare_sample($sformatf("buf_rdata frame %0d channel %0d", frame, c),
                           expected[c], buf_rdata);
        end
    endtask

    // A tick while idle must leave every frame confirmed so far untouched
    task automatic recheck_frames();
        sample_t words [N_CHANNELS];
        for (int f = 0; f < CHANNEL_SAMPLES; f++) begin
            if (frame_known[f]) begin
                for (int c = 0; c < N_CHANNELS; c++) begin
                    words[c] = frame_model[f][c];
                end
                check_frame(f, words);
            end
        end
    endtask

    initial begin
        int               fd;
        int               n_read;
        int               assert_errors;
        logic [7:0]       cmd;
        logic [8*100-1:0] comment_text;
        sample_t          arg_a;
        sample_t          arg_b;
        sample_t          frame_words [N_CHANNELS];
        void'($urandom(32'h5642_59ba));
        rst_n          = 1'b0;
        reg_wr         = 1'b0;
        reg_rd         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        in_valid       = 1'b0;
        in_data        = '0;
        in_dest        = '0;
        sampling_clock = 1'b0;
        buf_addr       = '0;
        capture_armed  = 1'b0;
        for (int c = 0; c < N_CHANNELS; c++) begin
            sel_model[c] = '0;
        end
        for (int f = 0; f < CHANNEL_SAMPLES; f++) begin
            frame_known[f] = 1'b0;
        end
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        fd = $fopen("sim/stream_scope_golden.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the golden file sim/stream_scope_golden.txt");
        end else begin
            // One command letter per line, its arguments follow on the same line
            while (!$feof(fd)) begin
                cmd    = '0;
                n_read = $fscanf(fd, "%s", cmd);
                if (n_read != 1) begin
                    break;
                end
                case (cmd)
                    "#": n_read = $fgets(comment_text, fd);
                    "W": begin
                        n_read = $fscanf(fd, "%h %h", arg_a, arg_b);
                        write_reg(reg_addr_t'(arg_a), arg_b);
                    end
                    "S": begin
                        n_read = $fscanf(fd, "%h %h", arg_a, arg_b);
                        send_word(dest_t'(arg_a), arg_b);
                    end
                    "R": begin
                        n_read = $fscanf(fd, "%h %h", arg_a, arg_b);
                        read_reg(reg_addr_t'(arg_a), arg_b);
                    end
                    "D": begin
                        n_read = $fscanf(fd, "%d", arg_a);
                        repeat (int'(arg_a)) @(negedge clock);
                    end
                    "E": begin
                        ext_tick();
                        // With no capture running the stored frames must not move
                        if (!capture_armed) begin
                            recheck_frames();
                        end
                    end
                    "P": begin
                        n_read = $fscanf(fd, "%d", arg_a);
                        wait_done(int'(arg_a));
                    end
                    "F": begin
                        n_read = $fscanf(fd, "%d", arg_a);
                        for (int c = 0; c < N_CHANNELS; c++) begin
                            n_read = $fscanf(fd, "%h", frame_words[c]);
                            frame_model[int'(arg_a)][c] = frame_words[c];
                        end
                        frame_known[int'(arg_a)] = 1'b1;
                        check_frame(int'(arg_a), frame_words);
                    end
                    default: begin
                        other_errors++;
                        $display("unknown command %s in the golden file", cmd);
                    end
                endcase
            end
            $fclose(fd);
        end
        if (done_count != done_expected) begin
            other_errors++;
            $display("dma_done pulsed %0d times over %0d captures", done_count, done_expected);
        end
        assert_errors = u_dut.u_checker.done_repeat_fails + u_dut.u_checker.done_idle_fails
                      + u_dut.u_checker.reset_fails;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- src/capture_buffer.sv
`timescale 1ns/1ps

module capture_buffer
    import scope_pkg::*;
#(
    parameter int N_CHANNELS      = 4,
    parameter int CHANNEL_SAMPLES = 8
) (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        sample_tick,
    input  sample_t     hold_values [N_CHANNELS],
    scope_cfg_if.buffer cfg,
    input  logic [$clog2(N_CHANNELS * CHANNEL_SAMPLES)-1:0] buf_addr,
    output sample_t     buf_rdata,
    output logic        dma_done
);

    localparam int DEPTH   = N_CHANNELS * CHANNEL_SAMPLES;
    localparam int FRAME_W = (CHANNEL_SAMPLES > 1) ? $clog2(CHANNEL_SAMPLES) : 1;
    localparam logic [FRAME_W-1:0] LAST_FRAME = FRAME_W'(CHANNEL_SAMPLES - 1);

    // Frames are stored back to back, so word f * N_CHANNELS + c holds
    // channel c of frame f and the readback address maps straight onto it
    sample_t mem [DEPTH];

    logic [FRAME_W-1:0] frame_cnt;
    logic               busy;
    logic               capture;
    logic               last_frame;

    // An arm in the same cycle as a tick restarts the capture and drops the tick
    assign capture    = sample_tick && busy && !cfg.arm;
    assign last_frame = (frame_cnt == LAST_FRAME);

    // Capture control
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            frame_cnt <= '0;
            dma_done  <= 1'b0;
        end else begin
            dma_done <= 1'b0;
            if (cfg.arm) begin
                // Arming again while busy starts over from frame zero
                busy      <= 1'b1;
                frame_cnt <= '0;
            end else if (capture) begin
                if (last_frame) begin
                    // Busy falls together with the done pulse
                    busy      <= 1'b0;
                    frame_cnt <= '0;
                    dma_done  <= 1'b1;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    // One tick writes a whole frame, every channel in parallel
    always_ff @(posedge clock) begin
        if (capture) begin
            for (int c = 0; c < N_CHANNELS; c++) begin
                mem[int'(frame_cnt) * N_CHANNELS + c] <= hold_values[c];
            end
        end
    end

    // Registered readback, valid one cycle after the address
    always_ff @(posedge clock) begin
        buf_rdata <= mem[buf_addr];
    end

    assign cfg.busy = busy;

endmodule

//--- src/channel_extractor.sv
`timescale 1ns/1ps

module channel_extractor
    import scope_pkg::*;
#(
    // Position of this channel in the selector array
    parameter int CHANNEL = 0
) (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         in_valid,
    input  sample_t      in_data,
    input  dest_t        in_dest,
    scope_cfg_if.extract cfg,
    output sample_t      hold_value
);

    logic tag_match;

    // A word belongs to this channel when its tag equals the channel selector
    // Several channels may share a selector and then all of them take the word
    assign tag_match = in_valid && (in_dest == cfg.selector[CHANNEL]);

    // The stream never stalls, so a matching word simply replaces the held value
    // The value stays put between matches, which lets the buffer sample it on
    // any tick regardless of the stream rate
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hold_value <= '0;
        end else if (tag_match) begin
            hold_value <= in_data;
        end
    end

endmodule

//--- src/sample_timebase.sv
`timescale 1ns/1ps

module sample_timebase
    import scope_pkg::*;
(
    input  logic          clock,
    input  logic          rst_n,
    input  logic          sampling_clock,
    scope_cfg_if.timebase cfg,
    output logic          sample_tick
);

    logic [DIV_WIDTH-1:0] div_cnt;
    logic                 div_wrap;
    logic                 ext_meta;
    logic                 ext_sync;
    logic                 ext_prev;
    logic                 ext_rise;

    // The count runs 0 to divider, which gives one wrap every divider + 1 cycles
    // A divider lowered below the current count wraps at once
    assign div_wrap = (div_cnt >= cfg.divider);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (div_wrap) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Two flops bring the external clock into this domain and a third keeps
    // the previous value for edge detection
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ext_meta <= 1'b0;
            ext_sync <= 1'b0;
            ext_prev <= 1'b0;
        end else begin
            ext_meta <= sampling_clock;
            ext_sync <= ext_meta;
            ext_prev <= ext_sync;
        end
    end

    assign ext_rise = ext_sync & ~ext_prev;

    // Registering the selected pulse puts the external tick three cycles
    // after the rising edge of sampling_clock
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= cfg.ext_capture ? ext_rise : div_wrap;
        end
    end

endmodule

//--- src/scope_cfg_if.sv
`timescale 1ns/1ps

interface scope_cfg_if
    import scope_pkg::*;
#(
    parameter int N_CHANNELS = 4
) ();

    // Levels held in the register block
    logic                 ext_capture;
    logic [DIV_WIDTH-1:0] divider;
    dest_t                selector [N_CHANNELS];

    // Single-cycle start request and the capture state fed back for status
    logic arm;
    logic busy;

    modport regs     (output ext_capture, output divider, output selector, output arm,
                      input busy);
    modport timebase (input ext_capture, input divider);
    modport extract  (input selector);
    modport buffer   (input arm, output busy);

endinterface

//--- src/scope_pkg.sv
package scope_pkg;

    // Stream and sample geometry
    localparam int DATA_WIDTH     = 32;
    localparam int DEST_WIDTH     = 8;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int DIV_WIDTH      = 16;

    // One captured sample as it travels from the stream to the frame store
    typedef logic [DATA_WIDTH-1:0] sample_t;

    // Destination tag carried by every stream word
    typedef logic [DEST_WIDTH-1:0] dest_t;

    // Word index on the register port
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // The control word sits at the bottom of the map
    localparam int REG_CTRL = 0;

    // Channel c has its selector at REG_SEL_BASE + c
    localparam int REG_SEL_BASE = 1;

    // The divider and the status word follow the last selector at these offsets
    localparam int REG_DIV_OFFSET    = 1;
    localparam int REG_STATUS_OFFSET = 2;

    // Writing this bit as 1 starts a capture and it never reads back as set
    localparam int CTRL_ARM_BIT = 0;

    // When set, ticks follow the external sampling clock instead of the divider
    localparam int CTRL_EXT_BIT = 24;

endpackage

//--- src/scope_regs.sv
`timescale 1ns/1ps

module scope_regs
    import scope_pkg::*;
#(
    parameter int N_CHANNELS = 4
) (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         reg_wr,
    input  logic         reg_rd,
    input  reg_addr_t    reg_addr,
    input  sample_t      reg_wdata,
    output sample_t      reg_rdata,
    scope_cfg_if.regs    cfg
);

    // The divider and status words sit right after the last selector
    localparam int LAST_SEL = REG_SEL_BASE + N_CHANNELS - 1;
    localparam reg_addr_t CTRL_ADDR   = reg_addr_t'(REG_CTRL);
    localparam reg_addr_t DIV_ADDR    = reg_addr_t'(LAST_SEL + REG_DIV_OFFSET);
    localparam reg_addr_t STATUS_ADDR = reg_addr_t'(LAST_SEL + REG_STATUS_OFFSET);

    sample_t ctrl_reg;
    sample_t div_reg;
    sample_t sel_reg [N_CHANNELS];
    logic    arm_q;
    sample_t rd_word;

    // Registers are kept at full width so every word reads back as written
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_reg <= '0;
            div_reg  <= '0;
            arm_q    <= 1'b0;
            for (int c = 0; c < N_CHANNELS; c++) begin
                sel_reg[c] <= '0;
            end
        end else begin
            // The arm request lives for exactly one cycle after the write
            arm_q <= 1'b0;
            if (reg_wr) begin
                if (reg_addr == CTRL_ADDR) begin
                    ctrl_reg               <= reg_wdata;
                    ctrl_reg[CTRL_ARM_BIT] <= 1'b0;
                    arm_q                  <= reg_wdata[CTRL_ARM_BIT];
                end
                if (reg_addr == DIV_ADDR) begin
                    div_reg <= reg_wdata;
                end
                for (int c = 0; c < N_CHANNELS; c++) begin
                    if (reg_addr == reg_addr_t'(REG_SEL_BASE + c)) begin
                        sel_reg[c] <= reg_wdata;
                    end
                end
            end
        end
    end

    // Read decode, unmapped words return zero
    always_comb begin
        rd_word = '0;
        if (reg_addr == CTRL_ADDR) begin
            rd_word = ctrl_reg;
        end
        if (reg_addr == DIV_ADDR) begin
            rd_word = div_reg;
        end
        if (reg_addr == STATUS_ADDR) begin
            rd_word = sample_t'(cfg.busy);
        end
        for (int c = 0; c < N_CHANNELS; c++) begin
            if (reg_addr == reg_addr_t'(REG_SEL_BASE + c)) begin
                rd_word = sel_reg[c];
            end
        end
    end

    // The read data is captured on the strobe and held until the next read
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_word;
        end
    end

    // Only the tag-wide part of a selector reaches the extractors
    always_comb begin
        for (int c = 0; c < N_CHANNELS; c++) begin
            cfg.selector[c] = sel_reg[c][DEST_WIDTH-1:0];
        end
    end

    assign cfg.ext_capture = ctrl_reg[CTRL_EXT_BIT];
    assign cfg.divider     = div_reg[DIV_WIDTH-1:0];
    assign cfg.arm         = arm_q;

endmodule

//--- src/stream_scope.sv
`timescale 1ns/1ps

module stream_scope
    import scope_pkg::*;
#(
    parameter int N_CHANNELS      = 4,
    parameter int CHANNEL_SAMPLES = 8
) (
    input  logic      clock,
    input  logic      rst_n,

    // Register port
    input  logic      reg_wr,
    input  logic      reg_rd,
    input  reg_addr_t reg_addr,
    input  sample_t   reg_wdata,
    output sample_t   reg_rdata,

    // Tagged sample stream, no back-pressure
    input  logic      in_valid,
    input  sample_t   in_data,
    input  dest_t     in_dest,

    // External sampling clock, asynchronous to clock
    input  logic      sampling_clock,

    // Frame readback and completion
    input  logic [$clog2(N_CHANNELS * CHANNEL_SAMPLES)-1:0] buf_addr,
    output sample_t   buf_rdata,
    output logic      dma_done
);

    // Configuration shared by all blocks
    scope_cfg_if #(.N_CHANNELS(N_CHANNELS)) cfg_if ();

    logic    sample_tick;
    sample_t hold_values [N_CHANNELS];

    scope_regs #(
        .N_CHANNELS (N_CHANNELS)
    ) u_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .cfg       (cfg_if.regs)
    );

    sample_timebase u_timebase (
        .clock          (clock),
        .rst_n          (rst_n),
        .sampling_clock (sampling_clock),
        .cfg            (cfg_if.timebase),
        .sample_tick    (sample_tick)
    );

    // One extractor per channel, all watching the same stream
    for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_channel
        channel_extractor #(
            .CHANNEL (ch)
        ) u_extractor (
            .clock      (clock),
            .rst_n      (rst_n),
            .in_valid   (in_valid),
            .in_data    (in_data),
            .in_dest    (in_dest),
            .cfg        (cfg_if.extract),
            .hold_value (hold_values[ch])
        );
    end

    capture_buffer #(
        .N_CHANNELS      (N_CHANNELS),
        .CHANNEL_SAMPLES (CHANNEL_SAMPLES)
    ) u_buffer (
        .clock       (clock),
        .rst_n       (rst_n),
        .sample_tick (sample_tick),
        .hold_values (hold_values),
        .cfg         (cfg_if.buffer),
        .buf_addr    (buf_addr),
        .buf_rdata   (buf_rdata),
        .dma_done    (dma_done)
    );

endmodule
